/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

        localparam int unsigned xlen = 32;

        typedef logic [xlen-1:0] word_t;
        typedef logic [4:0]      reg_addr_t;

        typedef enum logic [6:0] {
                opc_op     = 7'b0110011,
                opc_op_imm = 7'b0010011,
                opc_load   = 7'b0000011,
                opc_store  = 7'b0100011,
                opc_branch = 7'b1100011,
                opc_jal    = 7'b1101111,
                opc_jalr   = 7'b1100111,
                opc_lui    = 7'b0110111,
                opc_auipc  = 7'b0010111
        } opcode_e;

        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                alu_xor, alu_srl, alu_sra, alu_or, alu_and
        } alu_op_e;

        typedef enum logic [2:0] {
                br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
        } br_type_e;

        typedef enum logic [1:0] {
                wb_alu, wb_pc_plus4, wb_mem, wb_imm
        } wb_sel_e;

        typedef enum logic [1:0] {
                fwd_reg, fwd_from_mem, fwd_from_wb
        } fwd_sel_e;

        // Instruction formats, all 32 bits
        typedef struct packed {
                logic [6:0] funct7;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                reg_addr_t  rd;
                logic [6:0] opcode;
        } r_fmt_t;

        typedef struct packed {
                logic [11:0] imm12;
                reg_addr_t   rs1;
                logic [2:0]  funct3;
                reg_addr_t   rd;
                logic [6:0]  opcode;
        } i_fmt_t;

        typedef struct packed {
                logic [6:0] imm_hi;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                logic [4:0] imm_lo;
                logic [6:0] opcode;
        } s_fmt_t;

        typedef struct packed {
                logic [19:0] imm20;
                reg_addr_t   rd;
                logic [6:0]  opcode;
        } u_fmt_t;

        typedef union packed {
                r_fmt_t r_fmt;
                i_fmt_t i_fmt;
                s_fmt_t s_fmt;
                u_fmt_t u_fmt;
        } inst_u;

        typedef struct packed {
                logic     rs1_used;
                logic     rs2_used;
                logic     rf_we;
                wb_sel_e  wb_sel;
                logic     src1_pc;
                logic     src2_imm;
                alu_op_e  alu_op;
                br_type_e br_type;
                logic     jal;
                logic     jalr;
                logic     mem_we;
                logic     mem_re;
        } ctrl_t;

        typedef struct packed {
                word_t     pc;
                word_t     pc_plus4;
                reg_addr_t rs1;
                reg_addr_t rs2;
                reg_addr_t rd;
                word_t     rs1_data;
                word_t     rs2_data;
                word_t     imm;
                ctrl_t     ctrl;
        } id_ex_t;

        typedef struct packed {
                word_t     pc_plus4;
                reg_addr_t rd;
                word_t     alu_res;
                word_t     store_data;
                word_t     imm;
                logic      rf_we;
                wb_sel_e   wb_sel;
                logic      mem_we;
                logic      mem_re;
        } ex_mem_t;

        typedef struct packed {
                reg_addr_t rd;
                logic      rf_we;
                word_t     wb_data;
        } mem_wb_t;

        typedef struct packed {
                word_t addr;
                logic  we;
                word_t wdata;
        } dmem_req_t;

endpackage

`default_nettype wire

/* verilog/rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
        parameter word_t reset_pc = '0
) (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  stall,
        input  logic  flush,
        input  logic  redirect,
        input  word_t target,
        input  word_t im_dout,
        output word_t pc,
        output word_t id_pc,
        output inst_u id_inst
);

        // addi x0, x0, 0
        localparam inst_u nop_inst = 32'h0000_0013;

        always_ff @(posedge clk) begin
                if (!rst_n)
                        pc <= reset_pc;
                else if (redirect)
                        pc <= target;
                else if (!stall)
                        pc <= pc + 32'd4;
        end

        // IF/ID register
        always_ff @(posedge clk) begin
                if (!stall)
                        id_pc <= pc;
                if (!rst_n || flush)
                        id_inst <= nop_inst;
                else if (!stall)
                        id_inst <= im_dout;
        end

        // A load in EX never redirects, so the two cannot meet
        stall_vs_redirect: assert property (@(posedge clk) disable iff (!rst_n)
                !(stall && redirect))
                else $error("stall and redirect in the same cycle");

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode import rv_pkg::*; (
        input  inst_u     inst,
        input  word_t     pc,
        output ctrl_t     ctrl,
        output word_t     imm,
        output reg_addr_t rs1,
        output reg_addr_t rs2,
        output reg_addr_t rd
);

        logic [2:0] funct3;
        logic       alt;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;

        function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_sra);
                case (f3)
                        3'b000:  return sub_sra ? alu_sub : alu_add;
                        3'b001:  return alu_sll;
                        3'b010:  return alu_slt;
                        3'b011:  return alu_sltu;
                        3'b100:  return alu_xor;
                        3'b101:  return sub_sra ? alu_sra : alu_srl;
                        3'b110:  return alu_or;
                        default: return alu_and;
                endcase
        endfunction

        function automatic br_type_e br_decode(input logic [2:0] f3);
                case (f3)
                        3'b000:  return br_beq;
                        3'b001:  return br_bne;
                        3'b100:  return br_blt;
                        3'b101:  return br_bge;
                        3'b110:  return br_bltu;
                        3'b111:  return br_bgeu;
                        default: return br_none;
                endcase
        endfunction

        assign funct3 = inst.i_fmt.funct3;
        assign alt    = inst.r_fmt.funct7[5];

        assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
        assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
        // B reuses the S split with bits 11 and 12 moved
        assign imm_b = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_lo[0],
                        inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
        assign imm_u = {inst.u_fmt.imm20, 12'b0};
        assign imm_j = {{12{inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20[7:0],
                        inst.u_fmt.imm20[8], inst.u_fmt.imm20[18:9], 1'b0};

        always_comb begin
                ctrl = '0;
                imm  = '0;
                case (inst.r_fmt.opcode)
                        opc_op: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rs2_used = 1'b1;
                                ctrl.rf_we    = 1'b1;
                                ctrl.alu_op   = alu_decode(funct3, alt);
                        end
                        opc_op_imm: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rf_we    = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                // Only srai uses the funct7 bit here
                                ctrl.alu_op   = alu_decode(funct3, alt && funct3 == 3'b101);
                                imm           = imm_i;
                        end
                        opc_load: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rf_we    = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.wb_sel   = wb_mem;
                                ctrl.mem_re   = 1'b1;
                                imm           = imm_i;
                        end
                        opc_store: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rs2_used = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.mem_we   = 1'b1;
                                imm           = imm_s;
                        end
                        opc_branch: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rs2_used = 1'b1;
                                ctrl.src1_pc  = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.br_type  = br_decode(funct3);
                                imm           = imm_b;
                        end
                        opc_jal: begin
                                ctrl.rf_we    = 1'b1;
                                ctrl.src1_pc  = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.wb_sel   = wb_pc_plus4;
                                ctrl.jal      = 1'b1;
                                imm           = imm_j;
                        end
                        opc_jalr: begin
                                ctrl.rs1_used = 1'b1;
                                ctrl.rf_we    = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.wb_sel   = wb_pc_plus4;
                                ctrl.jalr     = 1'b1;
                                imm           = imm_i;
                        end
                        opc_lui: begin
                                ctrl.rf_we  = 1'b1;
                                ctrl.wb_sel = wb_imm;
                                imm         = imm_u;
                        end
                        opc_auipc: begin
                                // Sum formed here, written back as an immediate
                                ctrl.rf_we  = 1'b1;
                                ctrl.wb_sel = wb_imm;
                                imm         = pc + imm_u;
                        end
                        default: ;
                endcase
        end

        // Unused sources read as x0 so hazards never match them
        assign rs1 = ctrl.rs1_used ? inst.r_fmt.rs1 : '0;
        assign rs2 = ctrl.rs2_used ? inst.r_fmt.rs2 : '0;
        assign rd  = inst.r_fmt.rd;

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  reg_addr_t ra0,
        input  reg_addr_t ra1,
        input  mem_wb_t   wb,
        output word_t     rd0,
        output word_t     rd1
);

        word_t regs [1:31];

        function automatic word_t read_port(input reg_addr_t ra);
                if (ra == '0)
                        return '0;
                // Write-through from WB
                if (wb.rf_we && wb.rd == ra)
                        return wb.wb_data;
                return regs[ra];
        endfunction

        always_ff @(posedge clk) begin
                if (wb.rf_we && wb.rd != '0)
                        regs[wb.rd] <= wb.wb_data;
        end

        always_comb begin
                rd0 = read_port(ra0);
                rd1 = read_port(ra1);
        end

        x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
                (ra0 == '0 |-> rd0 == '0) and (ra1 == '0 |-> rd1 == '0))
                else $error("x0 read back nonzero");

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute import rv_pkg::*; (
        input  id_ex_t   id_ex,
        input  fwd_sel_e fwd0,
        input  fwd_sel_e fwd1,
        input  word_t    mem_fwd,
        input  word_t    wb_fwd,
        output ex_mem_t  ex_mem_next,
        output logic     redirect,
        output word_t    target
);

        word_t op_a;
        word_t op_b;
        word_t src1;
        word_t src2;
        word_t alu_res;
        logic  taken;

        function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                          input word_t mem_val, input word_t wb_val);
                case (sel)
                        fwd_from_mem: return mem_val;
                        fwd_from_wb:  return wb_val;
                        default:      return reg_val;
                endcase
        endfunction

        assign op_a = fwd_mux(fwd0, id_ex.rs1_data, mem_fwd, wb_fwd);
        assign op_b = fwd_mux(fwd1, id_ex.rs2_data, mem_fwd, wb_fwd);
        assign src1 = id_ex.ctrl.src1_pc ? id_ex.pc : op_a;
        assign src2 = id_ex.ctrl.src2_imm ? id_ex.imm : op_b;

        always_comb begin
                case (id_ex.ctrl.alu_op)
                        alu_sub:  alu_res = src1 - src2;
                        alu_sll:  alu_res = src1 << src2[4:0];
                        alu_slt:  alu_res = word_t'($signed(src1) < $signed(src2));
                        alu_sltu: alu_res = word_t'(src1 < src2);
                        alu_xor:  alu_res = src1 ^ src2;
                        alu_srl:  alu_res = src1 >> src2[4:0];
                        alu_sra:  alu_res = word_t'($signed(src1) >>> src2[4:0]);
                        alu_or:   alu_res = src1 | src2;
                        alu_and:  alu_res = src1 & src2;
                        default:  alu_res = src1 + src2;
                endcase
        end

        // Compare on the forwarded registers, not the ALU inputs
        always_comb begin
                case (id_ex.ctrl.br_type)
                        br_beq:  taken = op_a == op_b;
                        br_bne:  taken = op_a != op_b;
                        br_blt:  taken = $signed(op_a) < $signed(op_b);
                        br_bge:  taken = $signed(op_a) >= $signed(op_b);
                        br_bltu: taken = op_a < op_b;
                        br_bgeu: taken = op_a >= op_b;
                        default: taken = 1'b0;
                endcase
        end

        assign redirect = id_ex.ctrl.jal || id_ex.ctrl.jalr || taken;
        assign target   = id_ex.ctrl.jalr ? {alu_res[xlen-1:1], 1'b0} : alu_res;

        always_comb begin
                ex_mem_next.pc_plus4   = id_ex.pc_plus4;
                ex_mem_next.rd         = id_ex.rd;
                ex_mem_next.alu_res    = alu_res;
                ex_mem_next.store_data = op_b;
                ex_mem_next.imm        = id_ex.imm;
                ex_mem_next.rf_we      = id_ex.ctrl.rf_we;
                ex_mem_next.wb_sel     = id_ex.ctrl.wb_sel;
                ex_mem_next.mem_we     = id_ex.ctrl.mem_we;
                ex_mem_next.mem_re     = id_ex.ctrl.mem_re;
        end

endmodule

`default_nettype wire

/* verilog/rv_hazard.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_hazard import rv_pkg::*; (
        input  reg_addr_t id_rs1,
        input  reg_addr_t id_rs2,
        input  id_ex_t    id_ex,
        input  ex_mem_t   ex_mem,
        input  mem_wb_t   mem_wb,
        input  logic      redirect,
        output fwd_sel_e  fwd0,
        output fwd_sel_e  fwd1,
        output logic      stall,
        output logic      flush_id,
        output logic      flush_ex
);

        // Youngest producer wins
        function automatic fwd_sel_e fwd_pick(input reg_addr_t src);
                if (src == '0)
                        return fwd_reg;
                if (ex_mem.rf_we && ex_mem.rd == src)
                        return fwd_from_mem;
                if (mem_wb.rf_we && mem_wb.rd == src)
                        return fwd_from_wb;
                return fwd_reg;
        endfunction

        always_comb begin
                fwd0 = fwd_pick(id_ex.rs1);
                fwd1 = fwd_pick(id_ex.rs2);
        end

        // Load data only exists from WB on
        assign stall = id_ex.ctrl.mem_re && id_ex.rd != '0 &&
                       (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

        assign flush_id = redirect;
        assign flush_ex = redirect;

        // The stall bubble must keep a load out of MEM forwarding
        always_comb begin
                load_fwd_chk: assert final (ex_mem.mem_re !== 1'b1 ||
                        (fwd0 != fwd_from_mem && fwd1 != fwd_from_mem))
                        else $error("forward from a load still in MEM");
        end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; #(
        parameter word_t reset_pc = '0
) (
        input  logic      clk,
        input  logic      rst_n,
        output word_t     im_addr,
        input  word_t     im_dout,
        output dmem_req_t dmem,
        input  word_t     mem_dout
);

        word_t     pc;
        word_t     id_pc;
        inst_u     id_inst;
        ctrl_t     ctrl;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd0;
        word_t     rd1;
        id_ex_t    id_ex;
        ex_mem_t   ex_mem_next;
        ex_mem_t   ex_mem;
        mem_wb_t   mem_wb;
        word_t     mem_fwd;
        logic      redirect;
        word_t     target;
        fwd_sel_e  fwd0;
        fwd_sel_e  fwd1;
        logic      stall;
        logic      flush_id;
        logic      flush_ex;

        assign im_addr = pc;

        rv_fetch #(
                .reset_pc(reset_pc)
        ) u_fetch (
                .clk(clk),
                .rst_n(rst_n),
                .stall(stall),
                .flush(flush_id),
                .redirect(redirect),
                .target(target),
                .im_dout(im_dout),
                .pc(pc),
                .id_pc(id_pc),
                .id_inst(id_inst)
        );

        rv_decode u_decode (
                .inst(id_inst),
                .pc(id_pc),
                .ctrl(ctrl),
                .imm(imm),
                .rs1(rs1),
                .rs2(rs2),
                .rd(rd)
        );

        rv_regfile u_regfile (
                .clk(clk),
                .rst_n(rst_n),
                .ra0(rs1),
                .ra1(rs2),
                .wb(mem_wb),
                .rd0(rd0),
                .rd1(rd1)
        );

        // ID/EX register clears to a bubble on stall or flush
        always_ff @(posedge clk) begin
                if (!rst_n || stall || flush_ex) begin
                        id_ex <= '0;
                end else begin
                        id_ex.pc       <= id_pc;
                        id_ex.pc_plus4 <= id_pc + 32'd4;
                        id_ex.rs1      <= rs1;
                        id_ex.rs2      <= rs2;
                        id_ex.rd       <= rd;
                        id_ex.rs1_data <= rd0;
                        id_ex.rs2_data <= rd1;
                        id_ex.imm      <= imm;
                        id_ex.ctrl     <= ctrl;
                end
        end

        rv_execute u_execute (
                .id_ex(id_ex),
                .fwd0(fwd0),
                .fwd1(fwd1),
                .mem_fwd(mem_fwd),
                .wb_fwd(mem_wb.wb_data),
                .ex_mem_next(ex_mem_next),
                .redirect(redirect),
                .target(target)
        );

        rv_hazard u_hazard (
                .id_rs1(rs1),
                .id_rs2(rs2),
                .id_ex(id_ex),
                .ex_mem(ex_mem),
                .mem_wb(mem_wb),
                .redirect(redirect),
                .fwd0(fwd0),
                .fwd1(fwd1),
                .stall(stall),
                .flush_id(flush_id),
                .flush_ex(flush_ex)
        );

        always_ff @(posedge clk) begin
                ex_mem <= ex_mem_next;
                if (!rst_n) begin
                        ex_mem.rf_we  <= 1'b0;
                        ex_mem.mem_we <= 1'b0;
                        ex_mem.mem_re <= 1'b0;
                end
        end

        assign dmem.addr  = ex_mem.alu_res;
        assign dmem.we    = ex_mem.mem_we;
        assign dmem.wdata = ex_mem.store_data;

        // Non-load result of MEM
        always_comb begin
                case (ex_mem.wb_sel)
                        wb_pc_plus4: mem_fwd = ex_mem.pc_plus4;
                        wb_imm:      mem_fwd = ex_mem.imm;
                        default:     mem_fwd = ex_mem.alu_res;
                endcase
        end

        always_ff @(posedge clk) begin
                mem_wb.rd      <= ex_mem.rd;
                mem_wb.wb_data <= (ex_mem.wb_sel == wb_mem) ? mem_dout : mem_fwd;
                if (!rst_n)
                        mem_wb.rf_we <= 1'b0;
                else
                        mem_wb.rf_we <= ex_mem.rf_we;
        end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core import rv_pkg::*;;

        localparam logic [6:0] op_reg    = 7'b0110011;
        localparam logic [6:0] op_imm    = 7'b0010011;
        localparam logic [6:0] op_load   = 7'b0000011;
        localparam logic [6:0] op_store  = 7'b0100011;
        localparam logic [6:0] op_branch = 7'b1100011;
        localparam logic [6:0] op_jal    = 7'b1101111;
        localparam logic [6:0] op_jalr   = 7'b1100111;
        localparam logic [6:0] op_lui    = 7'b0110111;
        localparam logic [6:0] op_auipc  = 7'b0010111;
        localparam logic [11:0] poison_off = 12'd160;
        localparam int max_cycles = 400;

        logic      clk = 1'b0;
        logic      rst_n;
        word_t     im_addr;
        word_t     im_dout;
        dmem_req_t dmem;
        word_t     mem_dout;

        logic [31:0] imem [0:255];
        logic [31:0] dmem_arr [0:63];
        logic [31:0] init_data [0:7];
        // Reference register state while the program is built
        logic [31:0] xr [0:31];
        logic [31:0] pc_at;
        logic [31:0] exp_addr [0:31];
        logic [31:0] exp_data [0:31];
        string       exp_name [0:31];
        int          exp_count = 0;
        int          exp_idx = 0;
        int          seed;
        int          cycles;
        logic        reset_seen = 1'b0;

        always #2 clk = ~clk;

        rv_core #(
                .reset_pc(32'h0)
        ) u_dut (
                .clk(clk),
                .rst_n(rst_n),
                .im_addr(im_addr),
                .im_dout(im_dout),
                .dmem(dmem),
                .mem_dout(mem_dout)
        );

        assign im_dout  = imem[im_addr[9:2]];
        assign mem_dout = dmem_arr[dmem.addr[7:2]];

        always @(posedge clk) begin
                if (dmem.we)
                        dmem_arr[dmem.addr[7:2]] <= dmem.wdata;
                if (rst_n && dmem.we)
                        exp_idx <= exp_idx + 1;
                if (!rst_n)
                        reset_seen <= 1'b1;
        end

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("Test failed");
                $fatal(1);
        endtask

        function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
                case (f3)
                        3'd0:    return alt ? a - b : a + b;
                        3'd1:    return a << b[4:0];
                        3'd2:    return {31'b0, $signed(a) < $signed(b)};
                        3'd3:    return {31'b0, a < b};
                        3'd4:    return a ^ b;
                        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'd6:    return a | b;
                        default: return a & b;
                endcase
        endfunction

        task automatic emit(input logic [31:0] inst);
                imem[pc_at[9:2]] = inst;
                pc_at = pc_at + 32'd4;
        endtask

        task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
                if (rd != 5'd0)
                        xr[rd] = value;
        endtask

        task automatic op_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
                emit({f7, rs2, rs1, f3, rd, op_reg});
                set_reg(rd, alu_ref(f3, f7[5], xr[rs1], xr[rs2]));
        endtask

        task automatic op_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
                emit({imm, rs1, f3, rd, op_imm});
                // Bit 10 of the immediate selects srai
                set_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], xr[rs1], {{20{imm[11]}}, imm}));
        endtask

        task automatic load(input logic [4:0] rd, input logic [11:0] off);
                emit({off, 5'd0, 3'b010, rd, op_load});
                set_reg(rd, init_data[off[4:2]]);
        endtask

        // Stores go to consecutive words from word 16
        task automatic store(input string name, input logic [4:0] rs2);
                logic [11:0] off;
                off = 12'd64 + 12'(exp_count * 4);
                emit({off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_store});
                exp_addr[exp_count] = {20'b0, off};
                exp_data[exp_count] = xr[rs2];
                exp_name[exp_count] = name;
                exp_count++;
        endtask

        task automatic poison();
                emit({poison_off[11:5], 5'd1, 5'd0, 3'b010, poison_off[4:0], op_store});
        endtask

        task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [12:0] off);
                emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch});
        endtask

        task automatic jump(input logic [4:0] rd, input logic [20:0] off);
                set_reg(rd, pc_at + 32'd4);
                emit({off[20], off[10:1], off[11], off[19:12], rd, op_jal});
        endtask

        task automatic jump_reg(input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [11:0] imm);
                logic [31:0] link;
                link = pc_at + 32'd4;
                emit({imm, rs1, 3'b000, rd, op_jalr});
                set_reg(rd, link);
        endtask

        task automatic upper(input logic [6:0] opc, input logic [4:0] rd, input logic [19:0] imm);
                set_reg(rd, (opc == op_auipc ? pc_at : 32'h0) + {imm, 12'b0});
                emit({imm, rd, opc});
        endtask

        task automatic build_program();
                pc_at = 32'h0;
                xr[0] = 32'h0;
                load(5'd1, 12'd0);
                load(5'd2, 12'd4);
                op_rr(7'h00, 3'd0, 5'd3, 5'd1, 5'd2);
                store("load_use", 5'd3);
                load(5'd4, 12'd8);
                load(5'd5, 12'd12);
                // Dependent chain through MEM and WB forwarding
                op_rr(7'h20, 3'd0, 5'd6, 5'd4, 5'd5);
                op_rr(7'h00, 3'd4, 5'd7, 5'd6, 5'd5);
                op_rr(7'h00, 3'd6, 5'd8, 5'd7, 5'd6);
                op_rr(7'h00, 3'd7, 5'd9, 5'd8, 5'd4);
                op_rr(7'h00, 3'd1, 5'd10, 5'd9, 5'd5);
                op_rr(7'h00, 3'd5, 5'd11, 5'd10, 5'd2);
                op_rr(7'h20, 3'd5, 5'd12, 5'd10, 5'd11);
                op_rr(7'h00, 3'd2, 5'd13, 5'd12, 5'd7);
                op_rr(7'h00, 3'd3, 5'd14, 5'd12, 5'd7);
                op_ri(3'd0, 5'd15, 5'd14, 12'hffb);
                op_ri(3'd4, 5'd16, 5'd15, 12'h5a5);
                op_ri(3'd5, 5'd17, 5'd16, 12'h403);
                store("alu_sub", 5'd6);
                store("alu_xor", 5'd7);
                store("alu_or", 5'd8);
                store("alu_and", 5'd9);
                store("alu_sll", 5'd10);
                store("alu_srl", 5'd11);
                store("alu_sra", 5'd12);
                store("alu_slt", 5'd13);
                store("alu_sltu", 5'd14);
                store("alu_addi", 5'd15);
                store("alu_xori", 5'd16);
                store("alu_srai", 5'd17);
                branch(3'b000, 5'd1, 5'd1, 13'd12);
                poison();
                poison();
                branch(3'b001, 5'd1, 5'd1, 13'd8);
                op_ri(3'd0, 5'd19, 5'd0, 12'h123);
                store("not_taken", 5'd19);
                jump(5'd20, 21'd12);
                poison();
                poison();
                store("jal_link", 5'd20);
                // Odd sum checks that JALR clears bit 0
                op_ri(3'd0, 5'd21, 5'd0, 12'(pc_at + 32'd16));
                jump_reg(5'd22, 5'd21, 12'd1);
                poison();
                poison();
                store("jalr_link", 5'd22);
                upper(op_lui, 5'd23, 20'habcde);
                store("lui", 5'd23);
                upper(op_auipc, 5'd24, 20'h12345);
                store("auipc", 5'd24);
                jump(5'd0, 21'd0);
        endtask

        reset_chk: assert property (@(posedge clk)
                reset_seen && !(rst_n && $past(rst_n)) |-> !dmem.we && im_addr == 32'h0)
                else report_failure($sformatf(
                        "Mismatch in reset: expected we 0 pc %h, actual we %b pc %h",
                        32'h0, $sampled(dmem.we), $sampled(im_addr)));

        extra_store_chk: assert property (@(posedge clk) disable iff (!rst_n)
                dmem.we |-> exp_idx < exp_count)
                else report_failure($sformatf("Store to %h after all %0d expected stores",
                        $sampled(dmem.addr), exp_count));

        poison_chk: assert property (@(posedge clk) disable iff (!rst_n)
                dmem.we |-> dmem.addr != {20'b0, poison_off})
                else report_failure("A flushed instruction stored to the poison address");

        store_addr_chk: assert property (@(posedge clk) disable iff (!rst_n)
                dmem.we && exp_idx < exp_count |-> dmem.addr == exp_addr[exp_idx])
                else report_failure($sformatf("Mismatch in %s address: expected %h, actual %h",
                        exp_name[$sampled(exp_idx)], exp_addr[$sampled(exp_idx)],
                        $sampled(dmem.addr)));

        store_data_chk: assert property (@(posedge clk) disable iff (!rst_n)
                dmem.we && exp_idx < exp_count |-> dmem.wdata == exp_data[exp_idx])
                else report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                        exp_name[$sampled(exp_idx)], exp_data[$sampled(exp_idx)],
                        $sampled(dmem.wdata)));

        initial begin
                rst_n = 1'b0;
                seed = 92;
                // addi x0, x0, index
                for (int i = 0; i < 256; i++)
                        imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, op_imm};
                for (int i = 0; i < 64; i++)
                        dmem_arr[i] = {16'hd00d, 16'(i)};
                for (int i = 0; i < 8; i++) begin
                        init_data[i] = $random(seed);
                        dmem_arr[i]  = init_data[i];
                end
                build_program();
                repeat (3) @(posedge clk);
                #1 rst_n = 1'b1;
                cycles = 0;
                while (exp_idx < exp_count && cycles < max_cycles) begin
                        @(posedge clk);
                        cycles++;
                end
                // Drain so a stray late store is still caught
                repeat (8) @(posedge clk);
                if (exp_idx != exp_count) begin
                        report_failure($sformatf("Timed out with %0d of %0d stores seen",
                                exp_idx, exp_count));
                end else begin
                        $display("Test passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

/* files.f */
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_hazard.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_fetch.sv
  - verilog/rv_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_execute.sv
  - verilog/rv_hazard.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - sim/tb_rv_core.sv
